/* pad_pkg.sv */
// Pad ring definitions
// Pad counts, per-pad attribute word and the out/oe vector bundle
`default_nettype none

package pad_pkg;

  ////////////////////////////////////////
  // Pad counts
  ////////////////////////////////////////

  // Muxed pads sit at the bottom of every vector
  parameter int unsigned NumMioPads = 16;
  // Dedicated pads follow the muxed ones
  parameter int unsigned NumDioPads = 8;
  parameter int unsigned NumPads    = NumMioPads + NumDioPads;

  ////////////////////////////////////////
  // Pad attributes
  ////////////////////////////////////////

  // Software controlled, one per pad
  typedef struct packed {
    logic invert;      // Flip out and in
    logic open_drain;  // Drive low only
  } pad_attr_t;

  // Attribute register width as seen on APB
  parameter int unsigned AttrDw = $bits(pad_attr_t);

  ////////////////////////////////////////
  // Pad vectors
  ////////////////////////////////////////

  // Output data and output enable travel together down the pipeline
  typedef struct packed {
    logic [NumPads-1:0] out;
    logic [NumPads-1:0] oe;
  } pad_vec_t;

  // One attribute per pad
  typedef pad_attr_t [NumPads-1:0] pad_attr_arr_t;

endpackage

`default_nettype wire

/* jtag_pkg.sv */
// JTAG bundle and APB register map for the pad subsystem
`default_nettype none

package jtag_pkg;

  // Signals handed to the debug module
  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
    logic srst_n;
  } jtag_in_t;

  ////////////////////////////////////////
  // APB map
  ////////////////////////////////////////

  parameter int unsigned ApbAw = 8;   // Address bits
  parameter int unsigned ApbDw = 32;  // Data bits

  // First attribute register, one word per pad
  parameter logic [ApbAw-1:0] AttrBase   = 8'h00;
  parameter int unsigned      AttrStride = 4;

  // Trigger control, bit 0 enables gating
  parameter logic [ApbAw-1:0] TrigCtrlAddr = 8'h80;

endpackage

`default_nettype wire

/* pad_attr_regs.sv */
// APB register block for per-pad attributes
// One 2-bit attribute word per pad plus the trigger gating control
`timescale 1ns/1ps
`default_nettype none

module pad_attr_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  // APB slave
  input  logic [jtag_pkg::ApbAw-1:0]             paddr_i,
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [jtag_pkg::ApbDw-1:0]             pwdata_i,
  output logic [jtag_pkg::ApbDw-1:0]             prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  // To the datapath
  output pad_pkg::pad_attr_arr_t                 attr_o,
  output logic                                   trig_gate_en_o
);

  localparam int unsigned IdxW = jtag_pkg::ApbAw - 2;

  logic [jtag_pkg::ApbAw-1:0] attr_off;
  logic [IdxW-1:0]            attr_idx;
  logic                       attr_hit;
  logic                       trig_hit;
  logic                       access;

  pad_pkg::pad_attr_arr_t     attr_q;
  logic                       trig_gate_en_q;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign attr_off = paddr_i - jtag_pkg::AttrBase;
  assign attr_idx = attr_off[jtag_pkg::ApbAw-1:2];  // Word index

  // Word aligned, inside the attribute window
  assign attr_hit = (paddr_i >= jtag_pkg::AttrBase) &&
                    (attr_off[1:0] == 2'b00) &&
                    (attr_idx < IdxW'(pad_pkg::NumPads));
  assign trig_hit = (paddr_i == jtag_pkg::TrigCtrlAddr);

  assign access = psel_i & penable_i;  // Access phase

  // No wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~(attr_hit | trig_hit);

  ////////////////////////////////////////
  // Register write
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      attr_q         <= '0;
      trig_gate_en_q <= 1'b0;
    end else if (access && pwrite_i) begin
      for (int i = 0; i < pad_pkg::NumPads; i++) begin
        if (attr_hit && attr_idx == IdxW'(i)) begin
          attr_q[i] <= pad_pkg::pad_attr_t'(pwdata_i[pad_pkg::AttrDw-1:0]);
        end
      end
      if (trig_hit) begin
        trig_gate_en_q <= pwdata_i[0];
      end
    end
  end

  // Read mux, unmapped reads give zero
  always_comb begin
    prdata_o = '0;
    if (attr_hit) begin
      prdata_o[pad_pkg::AttrDw-1:0] = attr_q[attr_idx];
    end else if (trig_hit) begin
      prdata_o[0] = trig_gate_en_q;
    end
  end

  assign attr_o         = attr_q;
  assign trig_gate_en_o = trig_gate_en_q;

endmodule

`default_nettype wire

/* trigger_gate.sv */
// Stage 1 of the pad output path
// Registers the core vector and qualifies the capture trigger with crypto busy
`timescale 1ns/1ps
`default_nettype none

module trigger_gate #(
  parameter int unsigned TrigIdx = 15
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  pad_pkg::pad_vec_t core_i,
  input  logic              aes_busy_i,
  input  logic              gate_en_i,
  output pad_pkg::pad_vec_t vec_o
);

  pad_pkg::pad_vec_t vec_d;
  pad_pkg::pad_vec_t vec_q;

  // Trigger only fires while the cipher is running
  always_comb begin
    vec_d = core_i;
    if (gate_en_i) begin
      vec_d.out[TrigIdx] = core_i.out[TrigIdx] & aes_busy_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vec_q <= '0;
    end else begin
      vec_q <= vec_d;
    end
  end

  assign vec_o = vec_q;

endmodule

`default_nettype wire

/* jtag_overlay_mux.sv */
// Stage 2 of the pad output path
// Borrows the JTAG pads from the core when the strap pad requests debug
`timescale 1ns/1ps
`default_nettype none

module jtag_overlay_mux #(
  parameter int unsigned                      JtagEnIdx      = 16,
  parameter bit                               JtagEnPolarity = 1'b1,
  parameter int unsigned                      TckIdx         = 16,
  parameter int unsigned                      TmsIdx         = 17,
  parameter int unsigned                      TdiIdx         = 18,
  parameter int unsigned                      TdoIdx         = 19,
  parameter int unsigned                      TrstIdx        = 18,
  parameter int unsigned                      SrstIdx        = 19,
  parameter logic [pad_pkg::NumPads-1:0]      TieOffValues   = '0
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // Output path
  input  pad_pkg::pad_vec_t            vec_i,
  input  logic                         jtag_tdo_i,
  output pad_pkg::pad_vec_t            vec_o,
  // Input path, already registered by stage 3
  input  logic [pad_pkg::NumPads-1:0]  pad_in_i,
  output logic [pad_pkg::NumPads-1:0]  core_in_o,
  output jtag_pkg::jtag_in_t           jtag_o
);

  logic              jtag_en;
  pad_pkg::pad_vec_t vec_d;
  pad_pkg::pad_vec_t vec_q;

  // Strap pad decides who owns the JTAG pads
  assign jtag_en = (pad_in_i[JtagEnIdx] == JtagEnPolarity);

  ////////////////////////////////////////
  // Input side
  ////////////////////////////////////////

  always_comb begin
    core_in_o = pad_in_i;
    jtag_o    = '0;
    if (jtag_en) begin
      jtag_o.tck    = pad_in_i[TckIdx];
      jtag_o.tms    = pad_in_i[TmsIdx];
      jtag_o.tdi    = pad_in_i[TdiIdx];
      jtag_o.trst_n = pad_in_i[TrstIdx];
      jtag_o.srst_n = pad_in_i[SrstIdx];
      // Core sees idle levels on borrowed pads
      core_in_o[TckIdx]  = TieOffValues[TckIdx];
      core_in_o[TmsIdx]  = TieOffValues[TmsIdx];
      core_in_o[TdiIdx]  = TieOffValues[TdiIdx];
      core_in_o[TdoIdx]  = TieOffValues[TdoIdx];
      core_in_o[TrstIdx] = TieOffValues[TrstIdx];
      core_in_o[SrstIdx] = TieOffValues[SrstIdx];
    end
  end

  ////////////////////////////////////////
  // Output side
  ////////////////////////////////////////

  always_comb begin
    vec_d = vec_i;
    if (jtag_en) begin
      vec_d.oe[TckIdx]  = 1'b0;  // JTAG inputs float
      vec_d.oe[TmsIdx]  = 1'b0;
      vec_d.oe[TdiIdx]  = 1'b0;
      vec_d.oe[TrstIdx] = 1'b0;
      vec_d.oe[SrstIdx] = 1'b0;
      vec_d.out[TdoIdx] = jtag_tdo_i;
      vec_d.oe[TdoIdx]  = 1'b1;  // TDO always driven
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vec_q <= '0;
    end else begin
      vec_q <= vec_d;
    end
  end

  assign vec_o = vec_q;

endmodule

`default_nettype wire

/* pad_attr_stage.sv */
// Stage 3 of the pad output path
// Applies inversion and open-drain on the way out, inversion on the way in
`timescale 1ns/1ps
`default_nettype none

module pad_attr_stage (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  pad_pkg::pad_attr_arr_t       attr_i,
  input  pad_pkg::pad_vec_t            vec_i,
  input  logic [pad_pkg::NumPads-1:0]  pad_in_i,
  output logic [pad_pkg::NumPads-1:0]  pad_out_o,
  output logic [pad_pkg::NumPads-1:0]  pad_oe_o,
  output logic [pad_pkg::NumPads-1:0]  in_o
);

  logic [pad_pkg::NumPads-1:0] inv_mask;
  logic [pad_pkg::NumPads-1:0] od_mask;
  logic [pad_pkg::NumPads-1:0] out_inv;
  logic [pad_pkg::NumPads-1:0] out_d;
  logic [pad_pkg::NumPads-1:0] oe_d;
  logic [pad_pkg::NumPads-1:0] in_d;

  // Flatten the attribute words into per-bit masks
  always_comb begin
    for (int i = 0; i < pad_pkg::NumPads; i++) begin
      inv_mask[i] = attr_i[i].invert;
      od_mask[i]  = attr_i[i].open_drain;
    end
  end

  ////////////////////////////////////////
  // Attribute logic
  ////////////////////////////////////////

  assign out_inv = vec_i.out ^ inv_mask;
  assign out_d   = out_inv & ~od_mask;             // Open drain never drives high
  assign oe_d    = vec_i.oe & ~(od_mask & out_inv);  // Pull low only
  assign in_d    = pad_in_i ^ inv_mask;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pad_out_o <= '0;
      pad_oe_o  <= '0;
      in_o      <= '0;
    end else begin
      pad_out_o <= out_d;
      pad_oe_o  <= oe_d;
      in_o      <= in_d;
    end
  end

endmodule

`default_nettype wire

/* pad_io_top.sv */
// Pad side I/O subsystem
// Register block plus three registered stages between core and pads
`timescale 1ns/1ps
`default_nettype none

module pad_io_top #(
  parameter int unsigned                  JtagEnIdx      = 16,
  parameter bit                           JtagEnPolarity = 1'b1,
  parameter int unsigned                  TckIdx         = 16 + 0,
  parameter int unsigned                  TmsIdx         = 16 + 1,
  parameter int unsigned                  TdiIdx         = 16 + 2,
  parameter int unsigned                  TdoIdx         = 16 + 3,
  parameter int unsigned                  TrstIdx        = 18,
  parameter int unsigned                  SrstIdx        = 19,
  parameter int unsigned                  TrigIdx        = 15,
  // Shared chip select idles high
  parameter logic [pad_pkg::NumPads-1:0]  TieOffValues   = pad_pkg::NumPads'(1) << TmsIdx
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // APB
  input  logic [jtag_pkg::ApbAw-1:0]   paddr_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [jtag_pkg::ApbDw-1:0]   pwdata_i,
  output logic [jtag_pkg::ApbDw-1:0]   prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // Core side
  input  logic [pad_pkg::NumPads-1:0]  core_out_i,
  input  logic [pad_pkg::NumPads-1:0]  core_oe_i,
  output logic [pad_pkg::NumPads-1:0]  core_in_o,
  input  logic                         aes_busy_i,
  input  logic                         jtag_tdo_i,
  output jtag_pkg::jtag_in_t           jtag_o,
  // Pad side
  input  logic [pad_pkg::NumPads-1:0]  pad_in_i,
  output logic [pad_pkg::NumPads-1:0]  pad_out_o,
  output logic [pad_pkg::NumPads-1:0]  pad_oe_o
);

  pad_pkg::pad_attr_arr_t      attr;
  logic                        trig_gate_en;
  pad_pkg::pad_vec_t           core_vec;
  pad_pkg::pad_vec_t           s1_vec;        // After trigger gate
  pad_pkg::pad_vec_t           s2_vec;        // After JTAG overlay
  logic [pad_pkg::NumPads-1:0] pad_in_q;      // Registered, attribute adjusted

  assign core_vec = '{out: core_out_i, oe: core_oe_i};

  ////////////////////////////////////////
  // Registers and datapath
  ////////////////////////////////////////

  pad_attr_regs u_regs (
    .clk_i, .rst_i,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .attr_o         ( attr         ),
    .trig_gate_en_o ( trig_gate_en )
  );

  trigger_gate #(
    .TrigIdx ( TrigIdx )
  ) u_trig (
    .clk_i, .rst_i,
    .core_i     ( core_vec     ),
    .aes_busy_i,
    .gate_en_i  ( trig_gate_en ),
    .vec_o      ( s1_vec       )
  );

  jtag_overlay_mux #(
    .JtagEnIdx      ( JtagEnIdx      ),
    .JtagEnPolarity ( JtagEnPolarity ),
    .TckIdx         ( TckIdx         ),
    .TmsIdx         ( TmsIdx         ),
    .TdiIdx         ( TdiIdx         ),
    .TdoIdx         ( TdoIdx         ),
    .TrstIdx        ( TrstIdx        ),
    .SrstIdx        ( SrstIdx        ),
    .TieOffValues   ( TieOffValues   )
  ) u_jtag (
    .clk_i, .rst_i,
    .vec_i      ( s1_vec   ),
    .jtag_tdo_i,
    .vec_o      ( s2_vec   ),
    .pad_in_i   ( pad_in_q ),
    .core_in_o,
    .jtag_o
  );

  pad_attr_stage u_attr (
    .clk_i, .rst_i,
    .attr_i    ( attr     ),
    .vec_i     ( s2_vec   ),
    .pad_in_i,
    .pad_out_o,
    .pad_oe_o,
    .in_o      ( pad_in_q )
  );

endmodule

`default_nettype wire

/* pad_io_assertions.sv */
// Concurrent checks on the JTAG overlay and the APB error response
`timescale 1ns/1ps
`default_nettype none

module pad_io_assertions (
  input logic                       clk_i,
  input logic                       rst_i,
  input logic                       jtag_en_i,
  input jtag_pkg::jtag_in_t         jtag_i,
  input logic                       tdo_oe_i,   // Stage 2 oe of the TDO pad
  input logic                       access_i,
  input logic [jtag_pkg::ApbAw-1:0] addr_i,
  input logic                       pslverr_i
);

  localparam int unsigned attr_end = jtag_pkg::AttrBase +
                                     jtag_pkg::AttrStride * pad_pkg::NumPads;

  logic mapped;

  assign mapped = (addr_i == jtag_pkg::TrigCtrlAddr) ||
                  (addr_i >= jtag_pkg::AttrBase && addr_i < attr_end && addr_i[1:0] == 2'b00);

  jtag_idle_when_off: assert property (@(posedge clk_i) disable iff (rst_i)
    !jtag_en_i |-> jtag_i == '0)
    else $error("jtag_o not idle while JTAG is disabled");

  tdo_driven_when_on: assert property (@(posedge clk_i) disable iff (rst_i)
    jtag_en_i |=> tdo_oe_i)
    else $error("TDO pad not enabled while JTAG is enabled");

  slverr_only_unmapped: assert property (@(posedge clk_i) disable iff (rst_i)
    pslverr_i == (access_i && !mapped))
    else $error("pslverr does not match the address map at %h", addr_i);

endmodule

// Strap enable, JTAG mux output and APB decode as seen from the top level
bind pad_io_top pad_io_assertions u_sva (
  .clk_i, .rst_i,
  .jtag_en_i (pad_in_q[JtagEnIdx] == JtagEnPolarity),
  .jtag_i    (jtag_o),
  .tdo_oe_i  (s2_vec.oe[TdoIdx]),
  .access_i  (psel_i & penable_i),
  .addr_i    (paddr_i),
  .pslverr_i (pslverr_o)
);

`default_nettype wire

/* tb_pad_io.sv */
// Testbench for the pad side I/O subsystem
// LFSR stimulus, APB register accesses and a cycle model of the pad pipeline
`timescale 1ns/1ps
`default_nettype none

module tb_pad_io;

  localparam int unsigned   np          = pad_pkg::NumPads;
  localparam int unsigned   jtag_en_idx = 16;
  localparam bit            jtag_en_pol = 1'b1;
  localparam int unsigned   tck_idx     = 16;
  localparam int unsigned   tms_idx     = 17;
  localparam int unsigned   tdi_idx     = 18;
  localparam int unsigned   tdo_idx     = 19;
  localparam int unsigned   trst_idx    = 18;
  localparam int unsigned   srst_idx    = 19;
  localparam int unsigned   trig_idx    = 15;
  localparam logic [np-1:0] tie_off     = np'(1) << tms_idx;  // Chip select idles high
  localparam int unsigned   apb_timeout = 16;

  logic                       clk;
  logic                       rst;
  logic [jtag_pkg::ApbAw-1:0] paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [jtag_pkg::ApbDw-1:0] pwdata;
  logic [jtag_pkg::ApbDw-1:0] prdata;
  logic                       pready;
  logic                       pslverr;
  logic [np-1:0]              core_out;
  logic [np-1:0]              core_oe;
  logic [np-1:0]              core_in;
  logic                       aes_busy;
  logic                       jtag_tdo;
  jtag_pkg::jtag_in_t         jtag;
  logic [np-1:0]              pad_in;
  logic [np-1:0]              pad_out;
  logic [np-1:0]              pad_oe;

  logic [31:0]   lfsr;
  logic [np-1:0] sh_inv;  // Shadow attributes
  logic [np-1:0] sh_od;
  logic          sh_trig;
  logic [np-1:0] h_core_out [4];  // Index 0 is the newest cycle
  logic [np-1:0] h_core_oe [4];
  logic [np-1:0] h_pad_in [4];
  logic          h_busy [4];
  logic          h_tdo [4];
  int            errors;
  int            checks;
  int            err_base;
  int            tests_run;
  int            tests_failed;

  pad_io_top #(
    .JtagEnIdx (jtag_en_idx), .JtagEnPolarity (jtag_en_pol),
    .TckIdx (tck_idx), .TmsIdx (tms_idx), .TdiIdx (tdi_idx), .TdoIdx (tdo_idx),
    .TrstIdx (trst_idx), .SrstIdx (srst_idx), .TrigIdx (trig_idx),
    .TieOffValues (tie_off)
  ) dut (
    .clk_i (clk), .rst_i (rst),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .core_out_i (core_out), .core_oe_i (core_oe), .core_in_o (core_in),
    .aes_busy_i (aes_busy), .jtag_tdo_i (jtag_tdo), .jtag_o (jtag),
    .pad_in_i (pad_in), .pad_out_o (pad_out), .pad_oe_o (pad_oe)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic bit reg_mapped(input logic [7:0] addr);
    return (addr == 8'h80) || (addr < 8'(4 * np) && addr[1:0] == 2'b00);
  endfunction

  // One APB transfer, setup then access phase
  task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int unsigned waited;
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!pready && waited < apb_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      $display("APB transfer to %h never saw pready within %0d cycles", addr, apb_timeout);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_attrs_random();
    logic [31:0] d;
    logic [31:0] rd;
    logic        err;
    for (int i = 0; i < np; i++) begin
      d = take_bits(2);
      apb_xfer(8'(4 * i), 1'b1, d, rd, err);
      if (err) begin
        $display("Attribute write to pad %0d was rejected", i);
        errors++;
      end
      sh_inv[i] = d[1];
      sh_od[i]  = d[0];
    end
  endtask

  task automatic set_trig(input logic en);
    logic [31:0] rd;
    logic        err;
    apb_xfer(8'h80, 1'b1, {31'(take_bits(31)), en}, rd, err);
    sh_trig = en;
  endtask

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  task automatic check_cycle();
    logic [np-1:0]      in_now;
    logic [np-1:0]      in_old;
    logic [np-1:0]      exp_core_in;
    logic [np-1:0]      s_out;
    logic [np-1:0]      s_oe;
    logic [np-1:0]      out_inv;
    logic [np-1:0]      exp_out;
    logic [np-1:0]      exp_oe;
    jtag_pkg::jtag_in_t exp_jtag;
    in_now      = h_pad_in[1] ^ sh_inv;  // One input register
    exp_core_in = in_now;
    exp_jtag    = '0;
    if (in_now[jtag_en_idx] == jtag_en_pol) begin
      exp_jtag.tck    = in_now[tck_idx];
      exp_jtag.tms    = in_now[tms_idx];
      exp_jtag.tdi    = in_now[tdi_idx];
      exp_jtag.trst_n = in_now[trst_idx];
      exp_jtag.srst_n = in_now[srst_idx];
      exp_core_in[tck_idx]  = tie_off[tck_idx];
      exp_core_in[tms_idx]  = tie_off[tms_idx];
      exp_core_in[tdi_idx]  = tie_off[tdi_idx];
      exp_core_in[tdo_idx]  = tie_off[tdo_idx];
      exp_core_in[trst_idx] = tie_off[trst_idx];
      exp_core_in[srst_idx] = tie_off[srst_idx];
    end
    // Output side, three registers deep
    s_out = h_core_out[3];
    s_oe  = h_core_oe[3];
    if (sh_trig) begin
      s_out[trig_idx] = s_out[trig_idx] & h_busy[3];
    end
    in_old = h_pad_in[3] ^ sh_inv;  // Strap as seen by stage 2
    if (in_old[jtag_en_idx] == jtag_en_pol) begin
      s_oe[tck_idx]  = 1'b0;
      s_oe[tms_idx]  = 1'b0;
      s_oe[tdi_idx]  = 1'b0;
      s_oe[trst_idx] = 1'b0;
      s_oe[srst_idx] = 1'b0;
      s_out[tdo_idx] = h_tdo[2];
      s_oe[tdo_idx]  = 1'b1;
    end
    out_inv = s_out ^ sh_inv;
    exp_out = out_inv & ~sh_od;
    exp_oe  = s_oe & ~(sh_od & out_inv);  // Open drain only pulls low
    checks += 4;
    if (pad_out !== exp_out) begin
      $display("[FAIL] pad_out_o exp=%h got=%h", exp_out, pad_out);
      errors++;
    end
    if (pad_oe !== exp_oe) begin
      $display("[FAIL] pad_oe_o exp=%h got=%h", exp_oe, pad_oe);
      errors++;
    end
    if (core_in !== exp_core_in) begin
      $display("[FAIL] core_in_o exp=%h got=%h", exp_core_in, core_in);
      errors++;
    end
    if (jtag !== exp_jtag) begin
      $display("[FAIL] jtag_o exp=%h got=%h", exp_jtag, jtag);
      errors++;
    end
  endtask

  // Random datapath traffic, first cycles only fill the model history
  task automatic run_stream(input int unsigned cycles, input bit strap_on);
    logic [np-1:0] out_v;
    logic [np-1:0] oe_v;
    logic [np-1:0] in_v;
    logic          busy_v;
    logic          tdo_v;
    logic          active;
    for (int c = 0; c < cycles; c++) begin
      out_v  = np'(take_bits(np));
      oe_v   = np'(take_bits(np));
      in_v   = np'(take_bits(np));
      busy_v = 1'(take_bits(1));
      tdo_v  = 1'(take_bits(1));
      active = strap_on && (take_bits(3) != 0);  // Drops now and then
      in_v[jtag_en_idx] = sh_inv[jtag_en_idx] ^ (active ~^ jtag_en_pol);
      @(posedge clk);
      core_out <= out_v;
      core_oe  <= oe_v;
      pad_in   <= in_v;
      aes_busy <= busy_v;
      jtag_tdo <= tdo_v;
      for (int k = 3; k > 0; k--) begin
        h_core_out[k] = h_core_out[k-1];
        h_core_oe[k]  = h_core_oe[k-1];
        h_pad_in[k]   = h_pad_in[k-1];
        h_busy[k]     = h_busy[k-1];
        h_tdo[k]      = h_tdo[k-1];
      end
      h_core_out[0] = out_v;
      h_core_oe[0]  = oe_v;
      h_pad_in[0]   = in_v;
      h_busy[0]     = busy_v;
      h_tdo[0]      = tdo_v;
      @(negedge clk);
      if (c >= 3) begin
        check_cycle();
      end
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == err_base) begin
      $display("PASS  %s", name);
    end else begin
      tests_failed++;
      $display("FAIL  %s, %0d errors", name, errors - err_base);
    end
    err_base = errors;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] exp;
    logic        err;
    int unsigned idx;
    clk = 1'b0;
    rst = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    core_out = '0;
    core_oe = '0;
    aes_busy = 1'b0;
    jtag_tdo = 1'b0;
    pad_in = '0;
    lfsr = 32'h7c3d7d05;
    sh_inv = '0;
    sh_od = '0;
    sh_trig = 1'b0;
    errors = 0;
    checks = 0;
    err_base = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // Reset values
    @(negedge clk);
    checks += 2;
    if (pad_oe !== '0) begin
      $display("[FAIL] pad_oe_o exp=%h got=%h", {np{1'b0}}, pad_oe);
      errors++;
    end
    if (jtag !== '0) begin
      $display("[FAIL] jtag_o exp=%h got=%h", 5'h0, jtag);
      errors++;
    end
    for (int i = 0; i <= np; i++) begin
      addr = (i == np) ? 8'h80 : 8'(4 * i);
      apb_xfer(addr, 1'b0, '0, rdata, err);
      checks++;
      if (rdata !== '0 || err !== 1'b0) begin
        $display("[FAIL] prdata_o at %h exp=%h got=%h err=%h", addr, 32'h0, rdata, err);
        errors++;
      end
    end
    report_test("reset state");

    // Random register access over mapped and unmapped space
    for (int n = 0; n < 48; n++) begin
      if (take_bits(2) == 0) begin
        addr = 8'(take_bits(8));
      end else begin
        idx  = take_bits(5) % (np + 1);
        addr = (idx == np) ? 8'h80 : 8'(4 * idx);
      end
      wdata = take_bits(32);
      apb_xfer(addr, 1'b1, wdata, rdata, err);
      if (reg_mapped(addr) && addr == 8'h80) begin
        sh_trig = wdata[0];
      end else if (reg_mapped(addr)) begin
        sh_inv[addr[7:2]] = wdata[1];
        sh_od[addr[7:2]]  = wdata[0];
      end
      checks++;
      if (err !== !reg_mapped(addr)) begin
        $display("[FAIL] pslverr_o at %h exp=%h got=%h", addr, !reg_mapped(addr), err);
        errors++;
      end
      apb_xfer(addr, 1'b0, '0, rdata, err);
      exp = '0;
      if (addr == 8'h80) begin
        exp[0] = sh_trig;
      end else if (reg_mapped(addr)) begin
        exp[1:0] = {sh_inv[addr[7:2]], sh_od[addr[7:2]]};
      end
      checks++;
      if (rdata !== exp) begin
        $display("[FAIL] prdata_o at %h exp=%h got=%h", addr, exp, rdata);
        errors++;
      end
    end
    report_test("register access");

    set_trig(1'b0);
    write_attrs_random();
    run_stream(64, 1'b0);
    report_test("output pipeline with attributes");

    set_trig(1'b1);
    run_stream(64, 1'b0);
    set_trig(1'b0);
    run_stream(32, 1'b0);
    report_test("capture trigger gating");

    write_attrs_random();
    run_stream(64, 1'b1);
    report_test("JTAG overlay");

    write_attrs_random();
    run_stream(48, 1'b0);
    report_test("input path");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
pad_pkg.sv
jtag_pkg.sv
pad_attr_regs.sv
trigger_gate.sv
jtag_overlay_mux.sv
pad_attr_stage.sv
pad_io_top.sv
pad_io_assertions.sv
tb_pad_io.sv
